/* Makefile */
VERILATOR ?= verilator
TOP       ?= floor_logic_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
src/elevator_pkg.sv
src/request_latch.sv
src/request_stack.sv
src/dispatch_control.sv
src/floor_logic_top.sv
test/floor_logic_properties.sv
test/floor_logic_tb.sv

/* src/dispatch_control.sv */
// Target, direction and activate for the car controller, plus door request gating
`timescale 1ns/1ps

module dispatch_control (
    input  elevator_pkg::floor_t      top_floor,
    input  logic                      empty,
    input  elevator_pkg::car_status_t car,
    input  logic                      halt,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    input  logic                      power,
    output elevator_pkg::dispatch_t   dispatch,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    elevator_pkg::floor_t target;
    logic                 stopped;
    logic                 doors_ok;

    assign stopped = (car.motion == elevator_pkg::MOTION_STOP);

    ////////////////////////////////////////
    // Motion command
    ////////////////////////////////////////

    // With nothing pending the car is told to stay where it is
    assign target = empty ? car.floor : top_floor;

    assign dispatch.target       = target;
    // Equal floors count as up
    assign dispatch.direction_up = (target >= car.floor);
    assign dispatch.activate     = stopped
                                && !halt
                                && !empty
                                && (target != car.floor);

    ////////////////////////////////////////
    // Door permits
    ////////////////////////////////////////

    assign doors_ok = stopped && power;

    assign door_open_allowed  = doors_ok && door_open_button;
    assign door_close_allowed = doors_ok && door_close_button;

endmodule

/* src/elevator_pkg.sv */
// Shared constants and types for the elevator request logic, referenced by every RTL file
package elevator_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int NUM_FLOORS  = 11;
    localparam int STACK_DEPTH = 11;

    ////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////

    // Floor number 0 to 10
    typedef logic [3:0] floor_t;

    // One bit per floor for buttons and lights
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // Fill count of the request stack from 0 to 11
    typedef logic [3:0] stack_ptr_t;

    typedef enum logic [1:0] {
        MOTION_STOP      = 2'd0,
        MOTION_UP        = 2'd1,
        MOTION_DOWN      = 2'd2,
        MOTION_EMERGENCY = 2'd3
    } motion_e;

    ////////////////////////////////////////
    // Bundles between blocks
    ////////////////////////////////////////

    // Status reported by the car motion controller
    typedef struct packed {
        floor_t  floor;
        motion_e motion;
    } car_status_t;

    // New request from the latch into the stack
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } request_t;

    // Command to the car motion controller
    typedef struct packed {
        floor_t target;
        logic   direction_up;
        logic   activate;
    } dispatch_t;

endpackage

/* src/floor_logic_top.sv */
// Top level of the request side, connecting button latch, request stack and dispatch
`timescale 1ns/1ps

module floor_logic_top (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    input  logic                      emergency,
    input  logic                      power,
    input  elevator_pkg::car_status_t car,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights,
    output elevator_pkg::dispatch_t   dispatch,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    elevator_pkg::request_t push;
    elevator_pkg::floor_t   top_floor;
    logic                   empty;
    logic                   full;
    logic                   clear;

    request_latch u_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .call_buttons  (call_buttons),
        .panel_buttons (panel_buttons),
        .power         (power),
        .emergency     (emergency),
        .car           (car),
        .full          (full),
        .call_lights   (call_lights),
        .panel_lights  (panel_lights),
        .push          (push),
        .clear         (clear)
    );

    request_stack u_stack (
        .clock     (clock),
        .reset_n   (reset_n),
        .push      (push),
        .flush     (clear),
        .car       (car),
        .top_floor (top_floor),
        .empty     (empty),
        .full      (full)
    );

    // Same clear level holds the car while requests are wiped
    dispatch_control u_dispatch (
        .top_floor          (top_floor),
        .empty              (empty),
        .car                (car),
        .halt               (clear),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .power              (power),
        .dispatch           (dispatch),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

/* src/request_latch.sv */
// Button latch that turns hall-call and car-panel presses into lights and one stack push per cycle
`timescale 1ns/1ps

module request_latch (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      power,
    input  logic                      emergency,
    input  elevator_pkg::car_status_t car,
    input  logic                      full,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights,
    output elevator_pkg::request_t    push,
    output logic                      clear
);

    elevator_pkg::floor_mask_t at_floor;
    elevator_pkg::floor_mask_t stop_mask;
    elevator_pkg::floor_mask_t panel_ok;
    elevator_pkg::floor_mask_t call_ok;
    elevator_pkg::floor_mask_t sel_mask;
    elevator_pkg::floor_mask_t panel_set;
    elevator_pkg::floor_mask_t call_set;
    elevator_pkg::floor_t      sel_floor;
    logic                      sel_valid;
    logic                      sel_panel;
    logic                      accept_en;

    // Power loss or emergency wipes all pending work
    assign clear = !power || emergency;

    assign at_floor  = elevator_pkg::floor_mask_t'(1) << car.floor;
    assign stop_mask = (car.motion == elevator_pkg::MOTION_STOP) ? at_floor : '0;

    ////////////////////////////////////////
    // Eligible presses
    ////////////////////////////////////////

    assign accept_en = !clear && !full;
    assign panel_ok  = accept_en ? (panel_buttons & ~panel_lights & ~at_floor) : '0;
    assign call_ok   = accept_en ? (call_buttons & ~call_lights & ~at_floor) : '0;

    // Lowest floor wins inside a bank, and the panel bank overrides the call bank
    always_comb begin
        sel_valid = 1'b0;
        sel_panel = 1'b0;
        sel_floor = '0;
        for (int i = elevator_pkg::NUM_FLOORS - 1; i >= 0; i--) begin
            if (call_ok[i]) begin
                sel_valid = 1'b1;
                sel_floor = elevator_pkg::floor_t'(i);
            end
        end
        for (int i = elevator_pkg::NUM_FLOORS - 1; i >= 0; i--) begin
            if (panel_ok[i]) begin
                sel_valid = 1'b1;
                sel_panel = 1'b1;
                sel_floor = elevator_pkg::floor_t'(i);
            end
        end
    end

    assign sel_mask  = sel_valid ? (elevator_pkg::floor_mask_t'(1) << sel_floor) : '0;
    assign panel_set = sel_panel ? sel_mask : '0;
    assign call_set  = sel_panel ? '0 : sel_mask;

    assign push.valid = sel_valid;
    assign push.floor = sel_floor;

    ////////////////////////////////////////
    // Light registers
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
        end else if (clear) begin
            call_lights  <= '0;
            panel_lights <= '0;
        end else begin
            // A stopped car serves both banks at its floor
            call_lights  <= (call_lights | call_set) & ~stop_mask;
            panel_lights <= (panel_lights | panel_set) & ~stop_mask;
        end
    end

endmodule

/* src/request_stack.sv */
// LIFO of accepted floor requests; the top entry is the current dispatch target
`timescale 1ns/1ps

module request_stack (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::request_t    push,
    input  logic                      flush,
    input  elevator_pkg::car_status_t car,
    output elevator_pkg::floor_t      top_floor,
    output logic                      empty,
    output logic                      full
);

    elevator_pkg::floor_t     entries [elevator_pkg::STACK_DEPTH];
    elevator_pkg::stack_ptr_t count;
    elevator_pkg::stack_ptr_t top_idx;
    elevator_pkg::stack_ptr_t wr_idx;
    logic                     pop;

    assign empty   = (count == '0);
    assign full    = (count == elevator_pkg::stack_ptr_t'(elevator_pkg::STACK_DEPTH));
    assign top_idx = count - elevator_pkg::stack_ptr_t'(1);

    assign top_floor = empty ? '0 : entries[top_idx];

    // Served when the car stands still at the requested floor
    assign pop = !empty
              && (car.motion == elevator_pkg::MOTION_STOP)
              && (top_floor == car.floor);

    // Pop goes first, so a same-cycle push overwrites the served slot
    assign wr_idx = count - elevator_pkg::stack_ptr_t'(pop);

    ////////////////////////////////////////
    // Fill count
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else begin
            count <= wr_idx + elevator_pkg::stack_ptr_t'(push.valid);
        end
    end

    ////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (push.valid && !flush) begin
            entries[wr_idx] <= push.floor;
        end
    end

endmodule

/* test/floor_logic_properties.sv */
// Concurrent checks on the request logic, bound into floor_logic_top
`timescale 1ns/1ps

module floor_logic_properties (
    input logic                      clock,
    input logic                      reset_n,
    input elevator_pkg::car_status_t car,
    input elevator_pkg::floor_mask_t call_lights,
    input elevator_pkg::floor_mask_t panel_lights,
    input elevator_pkg::dispatch_t   dispatch,
    input elevator_pkg::request_t    push,
    input logic                      full,
    input logic                      door_open_allowed,
    input logic                      door_close_allowed
);

    logic stopped;
    logic moving;

    assign stopped = (car.motion == elevator_pkg::MOTION_STOP);
    assign moving  = (car.motion == elevator_pkg::MOTION_UP)
                  || (car.motion == elevator_pkg::MOTION_DOWN);

    assert property (@(posedge clock) disable iff (!reset_n)
        dispatch.activate |-> stopped)
        else $error("activate is high while the car is not stopped");

    // Lights of the floor where the car stood are off after the edge
    assert property (@(posedge clock) disable iff (!reset_n)
        stopped |=> ((call_lights | panel_lights)
                     & (elevator_pkg::floor_mask_t'(1) << $past(car.floor))) == '0)
        else $error("a light stayed on at the floor of a stopped car");

    assert property (@(posedge clock) disable iff (!reset_n)
        full |-> !push.valid)
        else $error("a request was pushed into a full stack");

    assert property (@(posedge clock) disable iff (!reset_n)
        moving |-> !door_open_allowed && !door_close_allowed)
        else $error("a door permit is high while the car moves");

endmodule

bind floor_logic_top floor_logic_properties u_properties (
    .clock              (clock),
    .reset_n            (reset_n),
    .car                (car),
    .call_lights        (call_lights),
    .panel_lights       (panel_lights),
    .dispatch           (dispatch),
    .push               (push),
    .full               (full),
    .door_open_allowed  (door_open_allowed),
    .door_close_allowed (door_close_allowed)
);

/* test/floor_logic_tb.sv */
// Testbench for floor_logic_top that replays the vector file, then runs seeded random presses
`timescale 1ns/1ps

module floor_logic_tb;

    localparam int HALF_PERIOD    = 5;
    localparam int MAX_VECTORS    = 64;
    localparam int MAX_WAIT       = 100;
    localparam int RANDOM_PRESSES = 24;

    // One line of the vector file, most significant field first
    typedef struct packed {
        logic [11:0] call;
        logic [11:0] panel;
        logic [3:0]  controls;
        logic [3:0]  floor;
        logic [3:0]  motion;
        logic [7:0]  hold;
        logic [11:0] exp_call;
        logic [11:0] exp_panel;
        logic [3:0]  exp_target;
        logic [3:0]  exp_flags;
    } test_vector_t;

    logic                      clock = 1'b0;
    logic                      reset_n;
    elevator_pkg::floor_mask_t call_buttons;
    elevator_pkg::floor_mask_t panel_buttons;
    logic                      door_open_button;
    logic                      door_close_button;
    logic                      emergency;
    logic                      power;
    elevator_pkg::car_status_t car;
    elevator_pkg::floor_mask_t call_lights;
    elevator_pkg::floor_mask_t panel_lights;
    elevator_pkg::dispatch_t   dispatch;
    logic                      door_open_allowed;
    logic                      door_close_allowed;

    logic [75:0]               vector_mem [MAX_VECTORS];
    test_vector_t              vec;
    elevator_pkg::floor_t      model_stack [$];
    elevator_pkg::floor_mask_t model_call;
    elevator_pkg::floor_mask_t model_panel;
    elevator_pkg::floor_mask_t press;
    elevator_pkg::floor_t      pick_floor;
    elevator_pkg::floor_t      exp_target;
    logic                      pick_panel;
    integer                    seed;
    int                        step;

    always #HALF_PERIOD clock = ~clock;

    floor_logic_top UUT (
        .clock              (clock),
        .reset_n            (reset_n),
        .call_buttons       (call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .emergency          (emergency),
        .power              (power),
        .car                (car),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .dispatch           (dispatch),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic wait_cycles(input int cycles);
        int waited;
        waited = 0;
        while (waited < cycles) begin
            if (waited >= MAX_WAIT) begin
                $display("Timeout: a wait ran longer than %0d clock cycles", MAX_WAIT);
                abort_run();
            end
            @(posedge clock);
            waited++;
        end
    endtask

    task automatic check_field(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        assert (got == expected) else begin
            $display("CHECK FAILED step %0d: %s = 0x%0h, expected 0x%0h",
                     step, name, got, expected);
            abort_run();
        end
    endtask

    // Flags are direction_up, activate, door_open_allowed, door_close_allowed from the top bit
    task automatic check_outputs(input logic [11:0] e_call, input logic [11:0] e_panel,
                                 input logic [3:0] e_target, input logic [3:0] e_flags);
        step++;
        check_field("call_lights", 16'(call_lights), 16'(e_call));
        check_field("panel_lights", 16'(panel_lights), 16'(e_panel));
        check_field("dispatch.target", 16'(dispatch.target), 16'(e_target));
        check_field("dispatch.direction_up", 16'(dispatch.direction_up), 16'(e_flags[3]));
        check_field("dispatch.activate", 16'(dispatch.activate), 16'(e_flags[2]));
        check_field("door_open_allowed", 16'(door_open_allowed), 16'(e_flags[1]));
        check_field("door_close_allowed", 16'(door_close_allowed), 16'(e_flags[0]));
    endtask

    initial begin
        reset_n           = 1'b0;
        call_buttons      = '0;
        panel_buttons     = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency         = 1'b0;
        power             = 1'b1;
        car.floor         = '0;
        car.motion        = elevator_pkg::MOTION_STOP;
        seed              = 32'h1e85_d898;
        step              = 0;
        for (int i = 0; i < MAX_VECTORS; i++) begin
            vector_mem[i] = '0;
        end
        $readmemh("test/floor_logic_tests.mem", vector_mem);
        if (vector_mem[0] == '0) begin
            $display("No test vectors could be read from the vector file");
            abort_run();
        end

        wait_cycles(2);
        @(negedge clock);
        reset_n = 1'b1;

        ////////////////////////////////////////
        // Directed vectors
        ////////////////////////////////////////
        // A hold count of zero marks the end of the file
        for (int i = 0; i < MAX_VECTORS; i++) begin
            vec = test_vector_t'(vector_mem[i]);
            if (vec.hold == 8'd0) break;
            call_buttons      = vec.call[10:0];
            panel_buttons     = vec.panel[10:0];
            door_open_button  = vec.controls[3];
            door_close_button = vec.controls[2];
            emergency         = vec.controls[1];
            power             = vec.controls[0];
            car.floor         = vec.floor;
            car.motion        = elevator_pkg::motion_e'(vec.motion[1:0]);
            wait_cycles(int'(vec.hold));
            #(HALF_PERIOD - 1);
            check_outputs(vec.exp_call, vec.exp_panel, vec.exp_target, vec.exp_flags);
            @(negedge clock);
        end

        ////////////////////////////////////////
        // Random presses with the car parked at floor 0
        ////////////////////////////////////////
        call_buttons      = '0;
        panel_buttons     = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency         = 1'b0;
        car.floor         = '0;
        car.motion        = elevator_pkg::MOTION_STOP;
        // One cycle without power starts the model from an empty stack
        power = 1'b0;
        wait_cycles(1);
        @(negedge clock);
        power       = 1'b1;
        model_call  = '0;
        model_panel = '0;
        for (int n = 0; n < RANDOM_PRESSES; n++) begin
            pick_panel    = 1'($random(seed));
            pick_floor    = elevator_pkg::floor_t'({$random(seed)} % elevator_pkg::NUM_FLOORS);
            press         = elevator_pkg::floor_mask_t'(1) << pick_floor;
            call_buttons  = pick_panel ? '0 : press;
            panel_buttons = pick_panel ? press : '0;
            // Floor 0 is the car floor and never accepted
            if (pick_floor != 4'd0 && model_stack.size() < elevator_pkg::STACK_DEPTH) begin
                if (pick_panel && (model_panel & press) == '0) begin
                    model_panel = model_panel | press;
                    model_stack.push_back(pick_floor);
                end else if (!pick_panel && (model_call & press) == '0) begin
                    model_call = model_call | press;
                    model_stack.push_back(pick_floor);
                end
            end
            exp_target = (model_stack.size() == 0) ? 4'd0 : model_stack[$];
            wait_cycles(1);
            #(HALF_PERIOD - 1);
            check_outputs(12'(model_call), 12'(model_panel), exp_target,
                          {1'b1, model_stack.size() != 0, 2'b00});
            @(negedge clock);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* test/floor_logic_tests.mem */
// call panel ctl(dopen,dclose,emerg,power) floor motion hold | exp_call exp_panel target
// flags(dir_up,activate,door_open_ok,door_close_ok); hold is in cycles, zero ends the list
000_000_1_0_0_01_000_000_0_8
000_020_1_0_0_01_000_020_5_C
000_000_1_0_0_01_000_020_5_C
000_000_1_3_1_02_000_020_5_8
000_000_1_5_0_01_000_000_5_8
008_000_1_5_0_01_008_000_3_4
000_100_1_5_0_01_008_100_8_C
000_000_1_6_1_02_008_100_8_8
000_000_1_8_0_01_008_000_3_4
000_100_1_8_0_01_008_000_3_4
008_000_1_8_0_01_008_000_3_4
600_2FF_1_8_0_0C_208_2FF_9_C
400_000_1_8_0_01_208_2FF_9_C
000_000_3_8_0_01_000_000_8_8
010_000_3_8_0_01_000_000_8_8
000_004_1_8_0_01_000_004_2_4
000_000_0_8_0_01_000_000_8_8
000_000_1_8_0_01_000_000_8_8
000_000_9_8_0_01_000_000_8_A
000_000_5_8_0_01_000_000_8_9
000_000_D_8_0_01_000_000_8_B
000_000_D_8_1_01_000_000_8_8
000_000_D_8_2_01_000_000_8_8
000_000_C_8_0_01_000_000_8_8
000_000_1_0_0_01_000_000_0_8
